// ==== design/smem_cfg_pkg.sv ====
package smem_cfg_pkg;

    // Bank organisation of the shared memory
    localparam int NUM_BANKS  = 4;
    localparam int BANK_SEL_W = $clog2(NUM_BANKS);

    // Each bank holds this many 32-bit words
    localparam int BANK_WORDS = 64;

    typedef logic [BANK_SEL_W-1:0] bank_sel_t;

endpackage

// ==== design/mem_bus_pkg.sv ====
package mem_bus_pkg;

    localparam int TAG_W      = 8;
    localparam int ADDR_W     = $clog2(smem_cfg_pkg::BANK_WORDS);
    localparam int DATA_W     = 32;
    // Banks never see the select bits, so their tag is narrower
    localparam int BANK_TAG_W = TAG_W - smem_cfg_pkg::BANK_SEL_W;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [DATA_W/8-1:0]   byteen_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [BANK_TAG_W-1:0] bank_tag_t;

    typedef struct packed {
        tag_t    tag;
        addr_t   addr;
        logic    rw;
        byteen_t byteen;
        data_t   data;
    } core_req_t;

    typedef struct packed {
        tag_t  tag;
        data_t data;
        logic  rw;
    } core_rsp_t;

    typedef struct packed {
        bank_tag_t tag;
        addr_t     addr;
        logic      rw;
        byteen_t   byteen;
        data_t     data;
    } bank_req_t;

    typedef struct packed {
        bank_tag_t tag;
        data_t     data;
        logic      rw;
    } bank_rsp_t;

endpackage

// ==== design/stream_switch.sv ====
`timescale 1ns/1ps

module stream_switch #(
    parameter int NUM_OUTPUTS = 2,
    parameter int DATAW       = 8,
    parameter int OUT_REG     = 1,
    localparam int SEL_W      = (NUM_OUTPUTS > 1) ? $clog2(NUM_OUTPUTS) : 1
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [SEL_W-1:0]                  sel_in,
    input  logic                              valid_in,
    output logic                              ready_in,
    input  logic [DATAW-1:0]                  data_in,
    output logic [NUM_OUTPUTS-1:0]            valid_out,
    input  logic [NUM_OUTPUTS-1:0]            ready_out,
    output logic [NUM_OUTPUTS-1:0][DATAW-1:0] data_out
);

    // Per output, whether it can take a new item this cycle
    logic [NUM_OUTPUTS-1:0] slot_ready;

    assign ready_in = slot_ready[sel_in];

    for (genvar i = 0; i < NUM_OUTPUTS; i++) begin : g_out
        logic take;

        assign take = valid_in && (sel_in == SEL_W'(i));

        if (OUT_REG != 0) begin : g_reg
            logic             valid_q;
            logic [DATAW-1:0] data_q;

            // Free slot or one that drains in this cycle
            assign slot_ready[i] = ~valid_q | ready_out[i];

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    valid_q <= 1'b0;
                end else if (slot_ready[i]) begin
                    valid_q <= take;
                end
            end

            always_ff @(posedge clk) begin
                if (take && slot_ready[i]) begin
                    data_q <= data_in;
                end
            end

            assign valid_out[i] = valid_q;
            assign data_out[i]  = data_q;
        end else begin : g_comb
            assign slot_ready[i] = ready_out[i];
            assign valid_out[i]  = take;
            assign data_out[i]   = data_in;
        end
    end

endmodule

// ==== design/stream_arb.sv ====
`timescale 1ns/1ps

module stream_arb #(
    parameter int NUM_INPUTS = 2,
    parameter int DATAW      = 8,
    parameter int OUT_REG    = 1,
    localparam int SEL_W     = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [NUM_INPUTS-1:0]            valid_in,
    output logic [NUM_INPUTS-1:0]            ready_in,
    input  logic [NUM_INPUTS-1:0][DATAW-1:0] data_in,
    output logic                             valid_out,
    input  logic                             ready_out,
    output logic [DATAW-1:0]                 data_out,
    output logic [SEL_W-1:0]                 sel_out
);

    logic [SEL_W-1:0] ptr_q;
    logic [SEL_W-1:0] grant_idx;
    logic             grant_valid;
    logic             stage_ready;
    logic             fire;
    // A grant that could not move on is kept for the next cycle
    logic             lock_q;
    logic [SEL_W-1:0] lock_idx_q;

    // Search downwards so the input nearest the pointer is taken last and wins
    always_comb begin
        grant_valid = 1'b0;
        grant_idx   = ptr_q;
        for (int k = NUM_INPUTS - 1; k >= 0; k--) begin
            if (valid_in[(int'(ptr_q) + k) % NUM_INPUTS]) begin
                grant_valid = 1'b1;
                grant_idx   = SEL_W'((int'(ptr_q) + k) % NUM_INPUTS);
            end
        end
        if (lock_q) begin
            grant_valid = valid_in[lock_idx_q];
            grant_idx   = lock_idx_q;
        end
    end

    assign fire = grant_valid && stage_ready;

    for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_ready
        assign ready_in[i] = fire && (grant_idx == SEL_W'(i));
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr_q      <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            if (fire) begin
                ptr_q <= SEL_W'((int'(grant_idx) + 1) % NUM_INPUTS);
            end
            lock_q     <= grant_valid && !stage_ready;
            lock_idx_q <= grant_idx;
        end
    end

    if (OUT_REG != 0) begin : g_reg
        logic             valid_q;
        logic [DATAW-1:0] data_q;
        logic [SEL_W-1:0] sel_q;

        assign stage_ready = ~valid_q | ready_out;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                valid_q <= 1'b0;
            end else if (stage_ready) begin
                valid_q <= grant_valid;
            end
        end

        // The winner index rides along with its data
        always_ff @(posedge clk) begin
            if (fire) begin
                data_q <= data_in[grant_idx];
                sel_q  <= grant_idx;
            end
        end

        assign valid_out = valid_q;
        assign data_out  = data_q;
        assign sel_out   = sel_q;
    end else begin : g_comb
        assign stage_ready = ready_out;
        assign valid_out   = grant_valid;
        assign data_out    = data_in[grant_idx];
        assign sel_out     = grant_idx;
    end

endmodule

// ==== design/smem_switch.sv ====
`timescale 1ns/1ps

module smem_switch #(
    parameter int TAG_SEL_IDX = 0,
    parameter int OUT_REG_REQ = 1,
    parameter int OUT_REG_RSP = 1
) (
    input  logic                                                  clk,
    input  logic                                                  arst_n,
    input  logic                                                  core_req_valid,
    input  mem_bus_pkg::core_req_t                                core_req,
    output logic                                                  core_req_ready,
    output logic                                                  core_rsp_valid,
    output mem_bus_pkg::core_rsp_t                                core_rsp,
    input  logic                                                  core_rsp_ready,
    output logic [smem_cfg_pkg::NUM_BANKS-1:0]                    bank_req_valid,
    output mem_bus_pkg::bank_req_t [smem_cfg_pkg::NUM_BANKS-1:0] bank_req,
    input  logic [smem_cfg_pkg::NUM_BANKS-1:0]                    bank_req_ready,
    input  logic [smem_cfg_pkg::NUM_BANKS-1:0]                    bank_rsp_valid,
    input  mem_bus_pkg::bank_rsp_t [smem_cfg_pkg::NUM_BANKS-1:0] bank_rsp,
    output logic [smem_cfg_pkg::NUM_BANKS-1:0]                    bank_rsp_ready
);

    import mem_bus_pkg::*;
    import smem_cfg_pkg::*;

    // Tag bits below the select field keep their position
    localparam tag_t LOW_MASK = tag_t'((1 << TAG_SEL_IDX) - 1);

    // Close the gap by shifting the upper tag bits down
    function automatic bank_tag_t strip_sel(tag_t tag);
        tag_t high;
        high = tag >> (TAG_SEL_IDX + BANK_SEL_W);
        return bank_tag_t'((high << TAG_SEL_IDX) | (tag & LOW_MASK));
    endfunction

    function automatic tag_t restore_sel(bank_tag_t btag, bank_sel_t sel);
        tag_t wide;
        wide = tag_t'(btag);
        return ((wide >> TAG_SEL_IDX) << (TAG_SEL_IDX + BANK_SEL_W))
             | (tag_t'(sel) << TAG_SEL_IDX)
             | (wide & LOW_MASK);
    endfunction

    bank_sel_t req_sel;
    bank_req_t req_in;
    bank_sel_t rsp_sel;
    bank_rsp_t rsp_out;

    assign req_sel = core_req.tag[TAG_SEL_IDX +: BANK_SEL_W];

    always_comb begin
        req_in.tag    = strip_sel(core_req.tag);
        req_in.addr   = core_req.addr;
        req_in.rw     = core_req.rw;
        req_in.byteen = core_req.byteen;
        req_in.data   = core_req.data;
    end

    stream_switch #(
        .NUM_OUTPUTS (NUM_BANKS),
        .DATAW       ($bits(bank_req_t)),
        .OUT_REG     (OUT_REG_REQ)
    ) req_switch (
        .clk       (clk),
        .arst_n    (arst_n),
        .sel_in    (req_sel),
        .valid_in  (core_req_valid),
        .ready_in  (core_req_ready),
        .data_in   (req_in),
        .valid_out (bank_req_valid),
        .ready_out (bank_req_ready),
        .data_out  (bank_req)
    );

    stream_arb #(
        .NUM_INPUTS (NUM_BANKS),
        .DATAW      ($bits(bank_rsp_t)),
        .OUT_REG    (OUT_REG_RSP)
    ) rsp_arb (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (bank_rsp_valid),
        .ready_in  (bank_rsp_ready),
        .data_in   (bank_rsp),
        .valid_out (core_rsp_valid),
        .ready_out (core_rsp_ready),
        .data_out  (rsp_out),
        .sel_out   (rsp_sel)
    );

    // The arbiter's winner is the bank number the request was sent to
    always_comb begin
        core_rsp.tag  = restore_sel(rsp_out.tag, rsp_sel);
        core_rsp.data = rsp_out.data;
        core_rsp.rw   = rsp_out.rw;
    end

endmodule

// ==== design/smem_bank.sv ====
`timescale 1ns/1ps

module smem_bank (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req_valid,
    input  mem_bus_pkg::bank_req_t req,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output mem_bus_pkg::bank_rsp_t rsp,
    input  logic                   rsp_ready
);

    import mem_bus_pkg::*;
    import smem_cfg_pkg::*;

    localparam int NUM_LANES = $bits(byteen_t);

    data_t mem [BANK_WORDS];
    logic  accept;

    // A held response that leaves this cycle frees the slot for a new one
    assign req_ready = ~rsp_valid | rsp_ready;
    assign accept    = req_valid & req_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (req.rw) begin
                for (int b = 0; b < NUM_LANES; b++) begin
                    if (req.byteen[b]) begin
                        mem[req.addr][8*b +: 8] <= req.data[8*b +: 8];
                    end
                end
                rsp.data <= '0;
            end else begin
                rsp.data <= mem[req.addr];
            end
            rsp.tag <= req.tag;
            rsp.rw  <= req.rw;
        end
    end

endmodule

// ==== design/smem_subsys_top.sv ====
`timescale 1ns/1ps

module smem_subsys_top #(
    parameter int TAG_SEL_IDX = 0,
    parameter int OUT_REG_REQ = 1,
    parameter int OUT_REG_RSP = 1
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   core_req_valid,
    input  mem_bus_pkg::core_req_t core_req,
    output logic                   core_req_ready,
    output logic                   core_rsp_valid,
    output mem_bus_pkg::core_rsp_t core_rsp,
    input  logic                   core_rsp_ready
);

    import mem_bus_pkg::*;
    import smem_cfg_pkg::*;

    logic      [NUM_BANKS-1:0] bank_req_valid;
    bank_req_t [NUM_BANKS-1:0] bank_req;
    logic      [NUM_BANKS-1:0] bank_req_ready;
    logic      [NUM_BANKS-1:0] bank_rsp_valid;
    bank_rsp_t [NUM_BANKS-1:0] bank_rsp;
    logic      [NUM_BANKS-1:0] bank_rsp_ready;

    smem_switch #(
        .TAG_SEL_IDX (TAG_SEL_IDX),
        .OUT_REG_REQ (OUT_REG_REQ),
        .OUT_REG_RSP (OUT_REG_RSP)
    ) smem_switch_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .bank_req_valid (bank_req_valid),
        .bank_req       (bank_req),
        .bank_req_ready (bank_req_ready),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp       (bank_rsp),
        .bank_rsp_ready (bank_rsp_ready)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        smem_bank smem_bank_inst (
            .clk       (clk),
            .arst_n    (arst_n),
            .req_valid (bank_req_valid[i]),
            .req       (bank_req[i]),
            .req_ready (bank_req_ready[i]),
            .rsp_valid (bank_rsp_valid[i]),
            .rsp       (bank_rsp[i]),
            .rsp_ready (bank_rsp_ready[i])
        );
    end

endmodule

// ==== tests/smem_switch_assertions.sv ====
`timescale 1ns/1ps

module smem_switch_assertions (
    input logic                                                  clk,
    input logic                                                  arst_n,
    input logic                                                  core_req_valid,
    input mem_bus_pkg::core_req_t                                core_req,
    input logic                                                  core_req_ready,
    input logic                                                  core_rsp_valid,
    input mem_bus_pkg::core_rsp_t                                core_rsp,
    input logic                                                  core_rsp_ready,
    input logic [smem_cfg_pkg::NUM_BANKS-1:0]                    bank_req_valid,
    input mem_bus_pkg::bank_req_t [smem_cfg_pkg::NUM_BANKS-1:0] bank_req,
    input logic [smem_cfg_pkg::NUM_BANKS-1:0]                    bank_req_ready,
    input logic [smem_cfg_pkg::NUM_BANKS-1:0]                    bank_rsp_valid,
    input mem_bus_pkg::bank_rsp_t [smem_cfg_pkg::NUM_BANKS-1:0] bank_rsp,
    input logic [smem_cfg_pkg::NUM_BANKS-1:0]                    bank_rsp_ready
);

    import smem_cfg_pkg::*;

    int fail_count = 0;

    assert property (@(posedge clk) disable iff (!arst_n)
        core_req_valid && !core_req_ready |=> core_req_valid && $stable(core_req))
    else begin
        fail_count++;
        $error("Core request changed while stalled");
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp))
    else begin
        fail_count++;
        $error("Core response changed while stalled");
    end

    // Stalled bank registers stay valid, so only newly loaded ones must be one-hot
    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(bank_req_valid & ~$past(bank_req_valid & ~bank_req_ready)))
    else begin
        fail_count++;
        $error("One request reached more than one bank");
    end

    assert property (@(posedge clk)
        !arst_n |-> !core_rsp_valid && bank_req_valid == '0 && bank_rsp_valid == '0)
    else begin
        fail_count++;
        $error("Valid output high during reset");
    end

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_link
        assert property (@(posedge clk) disable iff (!arst_n)
            bank_req_valid[i] && !bank_req_ready[i] |=>
                bank_req_valid[i] && $stable(bank_req[i]))
        else begin
            fail_count++;
            $error("Bank %0d request changed while stalled", i);
        end

        assert property (@(posedge clk) disable iff (!arst_n)
            bank_rsp_valid[i] && !bank_rsp_ready[i] |=>
                bank_rsp_valid[i] && $stable(bank_rsp[i]))
        else begin
            fail_count++;
            $error("Bank %0d response changed while stalled", i);
        end
    end

endmodule

bind smem_switch smem_switch_assertions switch_checks (.*);

// ==== tests/smem_subsys_tb.sv ====
`timescale 1ns/1ps

module smem_subsys_tb;

    import mem_bus_pkg::*;
    import smem_cfg_pkg::*;

    localparam int NUM_ROWS   = 24;
    localparam int CLK_HALF   = 20;
    localparam int RST_CYCLES = 8;
    // Budget of 50 cycles per row covers contention and random back-pressure
    localparam int TIMEOUT_NS = (NUM_ROWS * 50 + RST_CYCLES) * 2 * CLK_HALF;

    typedef struct packed {
        logic      rw;
        bank_sel_t bank;
        addr_t     addr;
        byteen_t   byteen;
        data_t     wdata;
        data_t     rdata;
    } row_t;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      core_req_valid;
    core_req_t core_req;
    logic      core_req_ready;
    logic      core_rsp_valid;
    core_rsp_t core_rsp;
    logic      core_rsp_ready;

    row_t rows [NUM_ROWS];
    logic answered [NUM_ROWS];
    int   num_sent;
    int   num_answered;
    int   num_checks;
    int   num_errors;

    smem_subsys_top smem_subsys_top_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic row_t make_row(logic rw, int bank, int addr, byteen_t be,
                                      data_t wd, data_t rd);
        row_t r;
        r.rw     = rw;
        r.bank   = bank_sel_t'(bank);
        r.addr   = addr_t'(addr);
        r.byteen = be;
        r.wdata  = wd;
        r.rdata  = rd;
        return r;
    endfunction

    // Expected read data is the hand-merged result of the earlier writes
    task automatic fill_table();
        rows[0]  = make_row(1'b1, 0,  5, 4'b1111, 32'h0a0a_0a00, 32'h0);
        rows[1]  = make_row(1'b1, 1,  5, 4'b1111, 32'h1b1b_1b11, 32'h0);
        rows[2]  = make_row(1'b1, 2,  5, 4'b1111, 32'h2c2c_2c22, 32'h0);
        rows[3]  = make_row(1'b1, 3,  5, 4'b1111, 32'h3d3d_3d33, 32'h0);
        rows[4]  = make_row(1'b0, 0,  5, 4'b0000, 32'h0,         32'h0a0a_0a00);
        rows[5]  = make_row(1'b0, 1,  5, 4'b0000, 32'h0,         32'h1b1b_1b11);
        rows[6]  = make_row(1'b0, 2,  5, 4'b0000, 32'h0,         32'h2c2c_2c22);
        rows[7]  = make_row(1'b0, 3,  5, 4'b0000, 32'h0,         32'h3d3d_3d33);
        rows[8]  = make_row(1'b1, 1, 12, 4'b1111, 32'h1122_3344, 32'h0);
        rows[9]  = make_row(1'b1, 1, 12, 4'b0101, 32'haabb_ccdd, 32'h0);
        rows[10] = make_row(1'b0, 1, 12, 4'b0000, 32'h0,         32'h11bb_33dd);
        rows[11] = make_row(1'b1, 2, 63, 4'b1111, 32'hcafe_f00d, 32'h0);
        rows[12] = make_row(1'b1, 2, 63, 4'b1000, 32'h1234_5678, 32'h0);
        rows[13] = make_row(1'b0, 2, 63, 4'b0000, 32'h0,         32'h12fe_f00d);
        rows[14] = make_row(1'b1, 3,  0, 4'b1111, 32'h0f0f_0f0f, 32'h0);
        rows[15] = make_row(1'b1, 3,  0, 4'b0011, 32'hf0f0_f0f0, 32'h0);
        rows[16] = make_row(1'b0, 3,  0, 4'b0000, 32'h0,         32'h0f0f_f0f0);
        rows[17] = make_row(1'b1, 0, 33, 4'b1111, 32'hdead_beef, 32'h0);
        rows[18] = make_row(1'b1, 0, 33, 4'b0110, 32'h0,         32'h0);
        rows[19] = make_row(1'b0, 0, 33, 4'b0000, 32'h0,         32'hde00_00ef);
        rows[20] = make_row(1'b1, 0,  5, 4'b0000, 32'h5555_aaaa, 32'h0);
        rows[21] = make_row(1'b0, 0,  5, 4'b0000, 32'h0,         32'h0a0a_0a00);
        rows[22] = make_row(1'b0, 3,  5, 4'b0000, 32'h0,         32'h3d3d_3d33);
        rows[23] = make_row(1'b0, 1, 12, 4'b0000, 32'h0,         32'h11bb_33dd);
    endtask

    // The row index sits above the select field and the bank number inside it
    function automatic tag_t row_tag(int idx);
        return tag_t'((idx << BANK_SEL_W) | int'(rows[idx].bank));
    endfunction

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic issue_row(int idx);
        logic accepted;
        core_req_valid  = 1'b1;
        core_req.tag    = row_tag(idx);
        core_req.addr   = rows[idx].addr;
        core_req.rw     = rows[idx].rw;
        core_req.byteen = rows[idx].byteen;
        core_req.data   = rows[idx].wdata;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = core_req_ready;
            @(posedge clk);
            #2;
        end
        num_sent++;
    endtask

    task automatic record_response();
        int idx;
        idx = int'(core_rsp.tag >> BANK_SEL_W);
        if (idx >= NUM_ROWS) begin
            num_errors++;
            $display("Response at %0t ns carries tag %h, which was never sent", $time,
                     core_rsp.tag);
        end else if (answered[idx]) begin
            num_errors++;
            $display("Row %0d was answered a second time at %0t ns", idx, $time);
        end else begin
            answered[idx] = 1'b1;
            num_answered++;
            check_value("core_rsp.tag", 32'(core_rsp.tag), 32'(row_tag(idx)));
            check_value("core_rsp.rw", 32'(core_rsp.rw), 32'(rows[idx].rw));
            check_value("core_rsp.data", core_rsp.data, rows[idx].rdata);
        end
    endtask

    // Both handshake sides are stable at the falling edge
    always @(negedge clk) begin
        if (!arst_n || num_sent == 0) begin
            check_value("core_rsp_valid", 32'(core_rsp_valid), 32'h0);
        end else if (core_rsp_valid && core_rsp_ready) begin
            record_response();
        end
    end

    // Core stalls responses in roughly a third of cycles
    initial begin
        void'($urandom(70));
        forever begin
            @(posedge clk);
            #2;
            core_rsp_ready = ($urandom % 3) != 0;
        end
    end

    initial begin
        int assert_fails;
        fill_table();
        arst_n         = 1'b1;
        core_req_valid = 1'b0;
        core_req       = '0;
        core_rsp_ready = 1'b0;
        num_sent       = 0;
        num_answered   = 0;
        num_checks     = 0;
        num_errors     = 0;
        foreach (answered[i]) begin
            answered[i] = 1'b0;
        end
        #2;
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            issue_row(i);
        end
        core_req_valid = 1'b0;
        wait (num_answered == NUM_ROWS);
        // Late duplicates would show up in this window
        repeat (20) @(posedge clk);
        assert_fails = smem_subsys_top_inst.smem_switch_inst.switch_checks.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 num_checks, num_errors, assert_fails);
        if (num_errors == 0 && assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout at %0t ns with %0d of %0d rows answered", $time, num_answered,
                 NUM_ROWS);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (!answered[i]) begin
                $display("Row %0d got no response", i);
            end
        end
        $display("Something failed");
        $finish;
    end

endmodule

// ==== tb.f ====
design/smem_cfg_pkg.sv
design/mem_bus_pkg.sv
design/stream_switch.sv
design/stream_arb.sv
design/smem_switch.sv
design/smem_bank.sv
design/smem_subsys_top.sv
tests/smem_switch_assertions.sv
tests/smem_subsys_tb.sv

// ==== Makefile ====
TOP := smem_subsys_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 2>&1 | tee $(LOG)
	@! grep -q "Something failed" $(LOG)
	@grep -q "Everything OK" $(LOG)

obj_dir/V$(TOP): tb.f $(wildcard design/*.sv tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir $(LOG)
